// ==== bench/adc_slave_model.sv ====
// Behavioral ADC slave for SPI modes 0 to 3; one 12-bit value per channel, one frame at a time
`timescale 1ns/1ps

module adc_slave_model #(
  parameter int SPI_MODE = 0
) (
  input  logic                                          i_spi_clk,
  input  logic                                          i_spi_cs_n,
  input  logic                                          i_spi_mosi,
  output logic                                          o_spi_miso,
  // Eight values, channel 0 in the low bits
  input  logic [8*$bits(spi_adc_pkg::adc_result_t)-1:0] i_table,
  // Capture of the last closed frame
  output logic [spi_adc_pkg::SPI_BYTE_W-1:0]            o_cmd_byte,
  output int                                            o_frame_edges,
  output int                                            o_frame_count
);

  import spi_adc_pkg::*;

  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);
  localparam int   RES_W = $bits(adc_result_t);
  localparam int   CH_W  = $bits(adc_ch_t);
  localparam int   FRAME_BITS = FRAME_BYTES * SPI_BYTE_W;
  // Frame bit where the result MSB goes out, after the command and four zeros
  localparam int   RES_FIRST = FRAME_BITS - RES_W;

  logic                  cs_q;
  logic                  sclk_q;
  int                    edge_cnt;
  int                    tx_cnt;
  int                    rx_cnt;
  logic [SPI_BYTE_W-1:0] cmd_shift;

  // Reply bit k of the frame, zero outside the result field
  function automatic logic reply_bit(input int k, input logic [SPI_BYTE_W-1:0] cmd);
    adc_ch_t     ch;
    adc_result_t val;
    begin
      ch  = cmd[CMD_START_BIT-1 -: CH_W];
      val = i_table[ch*RES_W +: RES_W];
      if ((k < RES_FIRST) || (k >= FRAME_BITS))
        reply_bit = 1'b0;
      else
        reply_bit = val[FRAME_BITS-1-k];
    end
  endfunction

  initial
  begin
    o_spi_miso    = 1'b0;
    o_cmd_byte    = '0;
    o_frame_edges = 0;
    o_frame_count = 0;
    cs_q          = 1'b1;
    sclk_q        = CPOL;
  end

  //////////////////////////////////////////////////////////////////////
  // Frame and edge tracking
  //////////////////////////////////////////////////////////////////////

  always @(i_spi_clk or i_spi_cs_n)
  begin
    if ((i_spi_cs_n === 1'b0) && (cs_q === 1'b1))
    begin
      // Frame opens
      edge_cnt  = 0;
      tx_cnt    = 0;
      rx_cnt    = 0;
      cmd_shift = '0;
      // CPHA=0 needs the first bit before the first leading edge
      if (!CPHA)
      begin
        o_spi_miso = reply_bit(0, cmd_shift);
        tx_cnt     = 1;
      end
    end
    else if ((i_spi_cs_n === 1'b1) && (cs_q === 1'b0))
    begin
      // Frame closes, publish what was seen
      o_frame_edges = edge_cnt;
      o_cmd_byte    = cmd_shift;
      o_frame_count = o_frame_count + 1;
      o_spi_miso    = 1'b0;
    end
    else if ((i_spi_cs_n === 1'b0) && (i_spi_clk !== sclk_q))
    begin
      edge_cnt = edge_cnt + 1;
      // Leading edge leaves the idle level
      if ((i_spi_clk !== CPOL) == CPHA)
      begin
        o_spi_miso = reply_bit(tx_cnt, cmd_shift);
        tx_cnt     = tx_cnt + 1;
      end
      else
      begin
        // Only the first byte is the command
        if (rx_cnt < SPI_BYTE_W)
          cmd_shift = {cmd_shift[SPI_BYTE_W-2:0], i_spi_mosi};
        rx_cnt = rx_cnt + 1;
      end
    end
    cs_q   = i_spi_cs_n;
    sclk_q = i_spi_clk;
  end

endmodule

// ==== bench/tb_adc_spi_top.sv ====
// ADC SPI front end testbench, SPI mode 1 with 4 clocks per half bit; random channels and values
`timescale 1ns/1ps

module tb_adc_spi_top;

  import spi_adc_pkg::*;

  localparam int   SPI_MODE    = 1;
  localparam int   HALF_BIT    = 4;
  localparam logic CPOL        = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam int   FRAME_EDGES = 2 * SPI_BYTE_W * FRAME_BYTES;
  localparam int   RES_W       = $bits(adc_result_t);
  localparam int   WAIT_LIMIT  = 2000;

  logic                  i_CLK;
  logic                  i_RSTN;
  logic                  i_start;
  adc_ch_t               i_channel;
  logic                  o_busy;
  logic                  o_result_valid;
  adc_result_t           o_result;
  logic                  spi_clk;
  logic                  spi_cs_n;
  logic                  spi_mosi;
  logic                  spi_miso;
  logic [8*RES_W-1:0]    table_flat;
  logic [SPI_BYTE_W-1:0] slv_cmd;
  int                    slv_edges;
  int                    slv_frames;

  // Scoreboard state
  int                    error_count;
  int                    check_count;
  int                    accepted_count;
  int                    dropped_count;
  int                    result_count;
  int                    seed_val;
  logic                  abort;
  string                 cur_test;
  adc_ch_t               exp_q[$];

  adc_spi_top #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (HALF_BIT),
    .CS_SETUP          (2),
    .CS_HOLD           (2)
  ) dut_i (
    .i_CLK          (i_CLK),
    .i_RSTN         (i_RSTN),
    .i_start        (i_start),
    .i_channel      (i_channel),
    .o_busy         (o_busy),
    .o_result_valid (o_result_valid),
    .o_result       (o_result),
    .o_spi_clk      (spi_clk),
    .o_spi_cs_n     (spi_cs_n),
    .o_spi_mosi     (spi_mosi),
    .i_spi_miso     (spi_miso)
  );

  adc_slave_model #(
    .SPI_MODE (SPI_MODE)
  ) slave_i (
    .i_spi_clk     (spi_clk),
    .i_spi_cs_n    (spi_cs_n),
    .i_spi_mosi    (spi_mosi),
    .o_spi_miso    (spi_miso),
    .i_table       (table_flat),
    .o_cmd_byte    (slv_cmd),
    .o_frame_edges (slv_edges),
    .o_frame_count (slv_frames)
  );

  always #4 i_CLK = ~i_CLK;

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic adc_result_t table_entry(input adc_ch_t ch);
    table_entry = table_flat[ch*RES_W +: RES_W];
  endfunction

  // Start bit, channel, four zero bits
  function automatic logic [SPI_BYTE_W-1:0] command_for(input adc_ch_t ch);
    command_for = {1'b1, ch, 4'b0000};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    begin
      check_count = check_count + 1;
      if (exp !== act)
      begin
        error_count = error_count + 1;
        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
      end
    end
  endtask

  task automatic report_timeout(input string what);
    begin
      error_count = error_count + 1;
      abort       = 1'b1;
      $display("Timeout in %s while waiting for %s", cur_test, what);
    end
  endtask

  // Inputs change 1 ns after the edge
  // Busy runs from an accepted start up to its result pulse
  task automatic drive_cycle(input logic start, input adc_ch_t ch);
    logic busy_exp;
    begin
      @(posedge i_CLK);
      #1;
      busy_exp = (exp_q.size() != 0) && (o_result_valid !== 1'b1);
      check_value({cur_test, ":busy"}, busy_exp, o_busy);
      i_start   = start;
      i_channel = ch;
      if (start && !busy_exp)
      begin
        exp_q.push_back(ch);
        accepted_count = accepted_count + 1;
      end
      else if (start)
      begin
        dropped_count = dropped_count + 1;
      end
    end
  endtask

  task automatic wait_idle();
    int cycles;
    begin
      cycles = 0;
      while (!abort && (o_busy || (exp_q.size() != 0)) && (cycles < WAIT_LIMIT))
      begin
        drive_cycle(1'b0, i_channel);
        cycles = cycles + 1;
      end
      if (!abort && (o_busy || (exp_q.size() != 0)))
        report_timeout("the conversion result");
    end
  endtask

  task automatic idle_cycles(input int n);
    begin
      for (int i = 0; i < n; i++)
        drive_cycle(1'b0, i_channel);
    end
  endtask

  // Every result is checked against the oldest accepted start
  always @(negedge i_CLK)
  begin : result_monitor
    adc_ch_t ch;
    if (i_RSTN)
    begin
      if (spi_cs_n === 1'b1)
        check_value({cur_test, ":sclk_idle"}, CPOL, spi_clk);
      if (o_result_valid === 1'b1)
      begin
        result_count = result_count + 1;
        if (exp_q.size() == 0)
        begin
          error_count = error_count + 1;
          $display("Result valid in %s with no accepted start pending", cur_test);
        end
        else
        begin
          ch = exp_q.pop_front();
          check_value({cur_test, ":result"}, table_entry(ch), o_result);
          check_value({cur_test, ":command"}, command_for(ch), slv_cmd);
          check_value({cur_test, ":sclk_edges"}, FRAME_EDGES, slv_edges);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_idle();
    begin
      cur_test = "reset_idle";
      check_value("reset_idle:cs_n", 1'b1, spi_cs_n);
      check_value("reset_idle:sclk", CPOL, spi_clk);
      check_value("reset_idle:mosi", 1'b0, spi_mosi);
      check_value("reset_idle:busy", 1'b0, o_busy);
      check_value("reset_idle:valid", 1'b0, o_result_valid);
      // No start, no activity
      for (int i = 0; i < 20; i++)
      begin
        drive_cycle(1'b0, '0);
        check_value("reset_idle:busy_quiet", 1'b0, o_busy);
      end
    end
  endtask

  task automatic run_single_conversion();
    int res_before;
    begin
      cur_test   = "single_conv";
      res_before = result_count;
      drive_cycle(1'b1, adc_ch_t'($urandom_range(0, 7)));
      wait_idle();
      idle_cycles(20);
      check_value("single_conv:result_count", 1, result_count - res_before);
    end
  endtask

  task automatic run_command_sweep();
    begin
      cur_test = "cmd_encoding";
      for (int i = 0; (i < 20) && !abort; i++)
      begin
        drive_cycle(1'b1, adc_ch_t'($urandom_range(0, 7)));
        wait_idle();
      end
    end
  endtask

  task automatic run_framing();
    int frm_before;
    begin
      cur_test   = "framing";
      frm_before = slv_frames;
      for (int i = 0; (i < 5) && !abort; i++)
      begin
        drive_cycle(1'b1, adc_ch_t'($urandom_range(0, 7)));
        wait_idle();
      end
      // A break in chip select would show up as extra frames
      check_value("framing:frame_count", 5, slv_frames - frm_before);
    end
  endtask

  task automatic run_busy_drop();
    int   acc_before;
    int   res_before;
    int   frm_before;
    int   drop_before;
    int   cycles;
    logic start;
    begin
      cur_test    = "busy_drop";
      acc_before  = accepted_count;
      res_before  = result_count;
      frm_before  = slv_frames;
      drop_before = dropped_count;
      cycles      = 0;
      while (!abort && ((accepted_count - acc_before) < 50) && (cycles < 50 * WAIT_LIMIT))
      begin
        // Frequent strobes while busy, random gaps while idle
        if (o_busy)
          start = ($urandom_range(0, 2) == 0);
        else
          start = ($urandom_range(0, 7) == 0);
        drive_cycle(start, adc_ch_t'($urandom_range(0, 7)));
        cycles = cycles + 1;
      end
      if (!abort && ((accepted_count - acc_before) < 50))
        report_timeout("50 accepted starts");
      wait_idle();
      idle_cycles(10);
      check_value("busy_drop:result_count", 50, result_count - res_before);
      check_value("busy_drop:frame_count", 50, slv_frames - frm_before);
      check_value("busy_drop:drops_seen", 1'b1, (dropped_count - drop_before) > 0);
    end
  endtask

  initial
  begin
    i_CLK          = 1'b0;
    i_RSTN         = 1'b0;
    i_start        = 1'b0;
    i_channel      = '0;
    error_count    = 0;
    check_count    = 0;
    accepted_count = 0;
    dropped_count  = 0;
    result_count   = 0;
    abort          = 1'b0;
    cur_test       = "reset";
    seed_val       = $urandom(56433);
    for (int k = 0; k < 8; k++)
      table_flat[k*RES_W +: RES_W] = adc_result_t'($urandom_range(0, 4095));

    repeat (10) @(posedge i_CLK);
    #1;
    i_RSTN = 1'b1;

    check_reset_idle();
    run_single_conversion();
    run_command_sweep();
    run_framing();
    run_busy_drop();

    $display("Checks: %0d  Errors: %0d  Accepted: %0d  Dropped: %0d  Results: %0d",
             check_count, error_count, accepted_count, dropped_count, result_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== logic/adc_read_seq.sv ====
// ADC read sequencer; a start while busy is dropped, and the result is held until the next frame
`timescale 1ns/1ps

module adc_read_seq (
  input  logic                               i_CLK,
  input  logic                               i_RSTN,
  // Host side
  input  logic                               i_start,
  input  spi_adc_pkg::adc_ch_t               i_channel,
  output logic                               o_busy,
  output logic                               o_result_valid,
  output spi_adc_pkg::adc_result_t           o_result,
  // Framer side
  output logic                               o_frame_start,
  input  logic                               i_byte_req,
  input  logic [1:0]                         i_byte_idx,
  output logic [spi_adc_pkg::SPI_BYTE_W-1:0] o_tx_byte,
  input  logic                               i_rx_dv,
  input  logic [spi_adc_pkg::SPI_BYTE_W-1:0] i_rx_byte,
  input  logic [1:0]                         i_rx_idx,
  input  logic                               i_frame_done
);

  import spi_adc_pkg::*;

  // Reply byte positions inside the frame
  localparam logic [1:0] CMD_IDX = 2'd0;
  localparam logic [1:0] HI_IDX  = 2'd1;
  localparam logic [1:0] LO_IDX  = 2'(FRAME_BYTES - 1);

  // High reply byte carries only the upper result bits in its low part
  localparam int HI_BITS = $bits(adc_result_t) - SPI_BYTE_W;

  adc_ch_t               ch_q;
  adc_result_t           result_asm;
  logic [SPI_BYTE_W-1:0] cmd_byte;
  logic                  accept;

  assign accept = i_start && !o_busy;

  //////////////////////////////////////////////////////////////////////
  // Host handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      o_busy         <= 1'b0;
      o_result_valid <= 1'b0;
      o_frame_start  <= 1'b0;
      ch_q           <= '0;
    end
    else
    begin
      o_result_valid <= 1'b0;
      o_frame_start  <= 1'b0;
      if (accept)
      begin
        ch_q          <= i_channel;
        o_busy        <= 1'b1;
        o_frame_start <= 1'b1;
      end
      else if (i_frame_done)
      begin
        // Busy drops together with the valid pulse
        o_busy         <= 1'b0;
        o_result_valid <= 1'b1;
      end
    end
  end

  // Command byte, start bit then channel then zero padding
  always_comb
  begin
    cmd_byte = '0;
    cmd_byte[CMD_START_BIT] = 1'b1;
    cmd_byte[CMD_START_BIT-1 -: $bits(adc_ch_t)] = ch_q;
  end

  // Reply bytes clock out zeros
  assign o_tx_byte = (i_byte_req && (i_byte_idx == CMD_IDX)) ? cmd_byte : '0;

  // Result assembly from the two reply bytes
  always_ff @(posedge i_CLK)
  begin
    if (i_rx_dv && (i_rx_idx == HI_IDX))
    begin
      result_asm[$bits(adc_result_t)-1 -: HI_BITS] <= i_rx_byte[HI_BITS-1:0];
    end
    if (i_rx_dv && (i_rx_idx == LO_IDX))
    begin
      result_asm[SPI_BYTE_W-1:0] <= i_rx_byte;
    end
    // Published once chip select is back up
    if (i_frame_done)
    begin
      o_result <= result_asm;
    end
  end

endmodule

// ==== logic/adc_spi_top.sv ====
// ADC SPI front end top level; single slave, one conversion per start, everything on i_CLK
`timescale 1ns/1ps

module adc_spi_top #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 4,
  parameter int CS_SETUP          = 2,
  parameter int CS_HOLD           = 2
) (
  input  logic                     i_CLK,
  input  logic                     i_RSTN,
  // Host
  input  logic                     i_start,
  input  spi_adc_pkg::adc_ch_t     i_channel,
  output logic                     o_busy,
  output logic                     o_result_valid,
  output spi_adc_pkg::adc_result_t o_result,
  // SPI pins
  output logic                     o_spi_clk,
  output logic                     o_spi_cs_n,
  output logic                     o_spi_mosi,
  input  logic                     i_spi_miso
);

  import spi_adc_pkg::*;

  // Sequencer to framer
  logic                  frame_start;
  logic                  byte_req;
  logic [1:0]            byte_idx;
  logic [SPI_BYTE_W-1:0] seq_tx_byte;
  logic                  frm_rx_dv;
  logic [SPI_BYTE_W-1:0] frm_rx_byte;
  logic [1:0]            frm_rx_idx;
  logic                  frame_done;

  // Framer to engine
  logic                  eng_tx_dv;
  logic [SPI_BYTE_W-1:0] eng_tx_byte;
  logic                  eng_tx_ready;
  logic                  eng_rx_dv;
  logic [SPI_BYTE_W-1:0] eng_rx_byte;

  //////////////////////////////////////////////////////////////////////
  // Command and result handling
  //////////////////////////////////////////////////////////////////////

  adc_read_seq seq_i (
    .i_CLK          (i_CLK),
    .i_RSTN         (i_RSTN),
    .i_start        (i_start),
    .i_channel      (i_channel),
    .o_busy         (o_busy),
    .o_result_valid (o_result_valid),
    .o_result       (o_result),
    .o_frame_start  (frame_start),
    .i_byte_req     (byte_req),
    .i_byte_idx     (byte_idx),
    .o_tx_byte      (seq_tx_byte),
    .i_rx_dv        (frm_rx_dv),
    .i_rx_byte      (frm_rx_byte),
    .i_rx_idx       (frm_rx_idx),
    .i_frame_done   (frame_done)
  );

  // Chip select around the three bytes
  spi_cs_frame #(
    .FRAME_LEN (FRAME_BYTES),
    .CS_SETUP  (CS_SETUP),
    .CS_HOLD   (CS_HOLD)
  ) frame_i (
    .i_CLK          (i_CLK),
    .i_RSTN         (i_RSTN),
    .i_frame_start  (frame_start),
    .o_byte_req     (byte_req),
    .o_byte_idx     (byte_idx),
    .i_tx_byte      (seq_tx_byte),
    .o_rx_dv        (frm_rx_dv),
    .o_rx_byte      (frm_rx_byte),
    .o_rx_idx       (frm_rx_idx),
    .o_frame_done   (frame_done),
    .o_spi_cs_n     (o_spi_cs_n),
    .o_eng_tx_dv    (eng_tx_dv),
    .o_eng_tx_byte  (eng_tx_byte),
    .i_eng_tx_ready (eng_tx_ready),
    .i_eng_rx_dv    (eng_rx_dv),
    .i_eng_rx_byte  (eng_rx_byte)
  );

  // Serial engine
  spi_master #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) master_i (
    .i_CLK      (i_CLK),
    .i_RSTN     (i_RSTN),
    .i_tx_byte  (eng_tx_byte),
    .i_tx_dv    (eng_tx_dv),
    .o_tx_ready (eng_tx_ready),
    .o_rx_dv    (eng_rx_dv),
    .o_rx_byte  (eng_rx_byte),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi)
  );

endmodule

// ==== logic/spi_adc_pkg.sv ====
// Frame constants and payload types for a 3-byte ADC read with a 12-bit result in two reply bytes

package spi_adc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////////////////////////

  // Converter input channel, eight channels
  typedef logic [2:0] adc_ch_t;

  // Conversion result as returned in the reply bytes
  typedef logic [11:0] adc_result_t;

  //////////////////////////////////////////////////////////////////////
  // Frame layout
  //////////////////////////////////////////////////////////////////////

  // Bits per serial byte
  localparam int SPI_BYTE_W = 8;

  // Command byte followed by two reply bytes
  localparam int FRAME_BYTES = 3;

  // Start bit sits in the MSB of the command byte
  // Channel bits follow right below it, then zero padding
  localparam int CMD_START_BIT = 7;

endpackage

// ==== logic/spi_cs_frame.sv ====
// Chip-select framer for up to 4 bytes per frame; CS_SETUP and CS_HOLD must be at least 1
`timescale 1ns/1ps

module spi_cs_frame #(
  parameter int FRAME_LEN = spi_adc_pkg::FRAME_BYTES,
  parameter int CS_SETUP  = 2,
  parameter int CS_HOLD   = 2
) (
  input  logic                               i_CLK,
  input  logic                               i_RSTN,
  input  logic                               i_frame_start,
  // Transmit byte fetch
  output logic                               o_byte_req,
  output logic [1:0]                         o_byte_idx,
  input  logic [spi_adc_pkg::SPI_BYTE_W-1:0] i_tx_byte,
  // Received bytes, tagged with their position
  output logic                               o_rx_dv,
  output logic [spi_adc_pkg::SPI_BYTE_W-1:0] o_rx_byte,
  output logic [1:0]                         o_rx_idx,
  output logic                               o_frame_done,
  output logic                               o_spi_cs_n,
  // Engine side
  output logic                               o_eng_tx_dv,
  output logic [spi_adc_pkg::SPI_BYTE_W-1:0] o_eng_tx_byte,
  input  logic                               i_eng_tx_ready,
  input  logic                               i_eng_rx_dv,
  input  logic [spi_adc_pkg::SPI_BYTE_W-1:0] i_eng_rx_byte
);

  // Gap counter covers the longer of setup and hold
  localparam int CNT_MAX = (CS_SETUP > CS_HOLD) ? CS_SETUP : CS_HOLD;
  localparam int CNT_W   = (CNT_MAX < 2) ? 1 : $clog2(CNT_MAX);
  localparam logic [1:0] LAST_IDX = 2'(FRAME_LEN - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SETUP,
    S_XFER,
    S_GAP,
    S_HOLD,
    S_DONE
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] gap_cnt;
  logic [1:0]       byte_idx;
  logic             launch;

  // Byte goes out as soon as the engine is free in the gap state
  // Fetch and launch share the cycle, the sequencer answers combinationally
  assign launch        = (state == S_GAP) && i_eng_tx_ready;
  assign o_byte_req    = launch;
  assign o_byte_idx    = byte_idx;
  assign o_eng_tx_dv   = launch;
  assign o_eng_tx_byte = i_tx_byte;

  // Received byte forwarded with the index of the byte in flight
  assign o_rx_dv   = (state == S_XFER) && i_eng_rx_dv;
  assign o_rx_byte = i_eng_rx_byte;
  assign o_rx_idx  = byte_idx;

  // Done strobe coincides with chip select rising
  assign o_frame_done = (state == S_DONE);

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      state      <= S_IDLE;
      gap_cnt    <= '0;
      byte_idx   <= '0;
      o_spi_cs_n <= 1'b1;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (i_frame_start)
          begin
            o_spi_cs_n <= 1'b0;
            gap_cnt    <= '0;
            byte_idx   <= '0;
            state      <= S_SETUP;
          end
        end
        S_SETUP:
        begin
          // Setup gap between CS fall and the first byte
          if (gap_cnt == CNT_W'(CS_SETUP - 1))
          begin
            state <= S_GAP;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_GAP:
        begin
          if (launch)
          begin
            state <= S_XFER;
          end
        end
        S_XFER:
        begin
          if (i_eng_rx_dv)
          begin
            if (byte_idx == LAST_IDX)
            begin
              gap_cnt <= '0;
              state   <= S_HOLD;
            end
            else
            begin
              byte_idx <= byte_idx + 1'b1;
              state    <= S_GAP;
            end
          end
        end
        S_HOLD:
        begin
          // Hold time, then also wait out the engine's last SCLK edge
          if ((gap_cnt == CNT_W'(CS_HOLD - 1)) && i_eng_tx_ready)
          begin
            o_spi_cs_n <= 1'b1;
            state      <= S_DONE;
          end
          else if (gap_cnt != CNT_W'(CS_HOLD - 1))
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_DONE:
        begin
          state <= S_IDLE;
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/spi_master.sv ====
// SPI byte engine without chip select; pulse i_tx_dv only when ready; CLKS_PER_HALF_BIT >= 2
`timescale 1ns/1ps

module spi_master #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 2
) (
  input  logic                               i_CLK,
  input  logic                               i_RSTN,
  // Transmit side
  input  logic [spi_adc_pkg::SPI_BYTE_W-1:0] i_tx_byte,
  input  logic                               i_tx_dv,
  output logic                               o_tx_ready,
  // Receive side
  output logic                               o_rx_dv,
  output logic [spi_adc_pkg::SPI_BYTE_W-1:0] o_rx_byte,
  // SPI pins
  output logic                               o_spi_clk,
  input  logic                               i_spi_miso,
  output logic                               o_spi_mosi
);

  import spi_adc_pkg::*;

  // Mode decode
  // CPOL sets the idle level, CPHA picks which edge launches data
  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);

  // Two SCLK edges per bit
  localparam int BYTE_EDGES = 2 * SPI_BYTE_W;
  localparam int HALF_CNT_W = $clog2(2 * CLKS_PER_HALF_BIT);
  localparam int EDGE_CNT_W = $clog2(BYTE_EDGES + 1);
  localparam int BIT_CNT_W  = $clog2(SPI_BYTE_W);

  // Counter values where the internal clock toggles
  localparam logic [HALF_CNT_W-1:0] LEAD_AT  = HALF_CNT_W'(CLKS_PER_HALF_BIT - 1);
  localparam logic [HALF_CNT_W-1:0] TRAIL_AT = HALF_CNT_W'(2 * CLKS_PER_HALF_BIT - 1);
  localparam logic [BIT_CNT_W-1:0]  MSB_IDX  = BIT_CNT_W'(SPI_BYTE_W - 1);

  logic [HALF_CNT_W-1:0] half_cnt;
  logic [EDGE_CNT_W-1:0] edge_cnt;
  logic                  sclk_int;
  logic                  lead_edge;
  logic                  trail_edge;
  logic                  tx_dv_q;
  logic [SPI_BYTE_W-1:0] tx_byte_q;
  logic [BIT_CNT_W-1:0]  tx_bit;
  logic [BIT_CNT_W-1:0]  rx_bit;
  logic                  shift_edge;
  logic                  sample_edge;

  //////////////////////////////////////////////////////////////////////
  // SCLK generation
  //////////////////////////////////////////////////////////////////////

  // Edge counter loads 16 on a new byte and counts down per toggle
  // Half-bit counter paces the toggles
  // Edge flags are one cycle wide, one cycle after the toggle
  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      o_tx_ready <= 1'b0;
      edge_cnt   <= '0;
      half_cnt   <= '0;
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
      sclk_int   <= CPOL;
    end
    else
    begin
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
      if (i_tx_dv)
      begin
        o_tx_ready <= 1'b0;
        edge_cnt   <= EDGE_CNT_W'(BYTE_EDGES);
        half_cnt   <= '0;
      end
      else if (edge_cnt != '0)
      begin
        o_tx_ready <= 1'b0;
        if (half_cnt == TRAIL_AT)
        begin
          // Return to idle level, end of bit
          edge_cnt   <= edge_cnt - 1'b1;
          trail_edge <= 1'b1;
          half_cnt   <= '0;
          sclk_int   <= ~sclk_int;
        end
        else if (half_cnt == LEAD_AT)
        begin
          // Leave idle level, middle of bit
          edge_cnt  <= edge_cnt - 1'b1;
          lead_edge <= 1'b1;
          half_cnt  <= half_cnt + 1'b1;
          sclk_int  <= ~sclk_int;
        end
        else
        begin
          half_cnt <= half_cnt + 1'b1;
        end
      end
      else
      begin
        // All 16 edges done, ready for the next byte
        o_tx_ready <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////////////////////////

  // Delayed strobe marks the CPHA=0 preload cycle
  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      tx_dv_q <= 1'b0;
    end
    else
    begin
      tx_dv_q <= i_tx_dv;
    end
  end

  // Local copy so the source may change after the strobe
  always_ff @(posedge i_CLK)
  begin
    if (i_tx_dv)
    begin
      tx_byte_q <= i_tx_byte;
    end
  end

  // CPHA=1 launches on leading edges
  // CPHA=0 launches on trailing edges, the last one carries no new bit
  assign shift_edge = CPHA ? lead_edge : (trail_edge && (edge_cnt != '0));

  // MOSI shifts MSB first
  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      o_spi_mosi <= 1'b0;
      tx_bit     <= MSB_IDX;
    end
    else if (o_tx_ready)
    begin
      tx_bit <= MSB_IDX;
    end
    else if (tx_dv_q && !CPHA)
    begin
      // First bit must be on the line before the first leading edge
      o_spi_mosi <= tx_byte_q[MSB_IDX];
      tx_bit     <= MSB_IDX - 1'b1;
    end
    else if (shift_edge)
    begin
      o_spi_mosi <= tx_byte_q[tx_bit];
      tx_bit     <= tx_bit - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////////////////////////

  // Sample on the edge opposite to the launch edge
  assign sample_edge = CPHA ? trail_edge : lead_edge;

  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      o_rx_dv <= 1'b0;
      rx_bit  <= MSB_IDX;
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (o_tx_ready)
      begin
        rx_bit <= MSB_IDX;
      end
      else if (sample_edge)
      begin
        rx_bit <= rx_bit - 1'b1;
        // Bit 0 just landed
        if (rx_bit == '0)
        begin
          o_rx_dv <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_CLK)
  begin
    if (!o_tx_ready && sample_edge)
    begin
      o_rx_byte[rx_bit] <= i_spi_miso;
    end
  end

  // One stage on SCLK so the pin lines up with MOSI
  always_ff @(posedge i_CLK or negedge i_RSTN)
  begin
    if (!i_RSTN)
    begin
      o_spi_clk <= CPOL;
    end
    else
    begin
      o_spi_clk <= sclk_int;
    end
  end

endmodule

// ==== sim.f ====
logic/spi_adc_pkg.sv
logic/spi_master.sv
logic/spi_cs_frame.sv
logic/adc_read_seq.sv
logic/adc_spi_top.sv
bench/adc_slave_model.sv
bench/tb_adc_spi_top.sv
